//--- logic/eeprom_pkg.sv
package eeprom_pkg;

    // one scl bit is four quarters
    localparam int QTR_CYCLES = 4;
    localparam int QCNT_W     = $clog2(QTR_CYCLES);
    localparam logic [QCNT_W-1:0] QCNT_LAST = QCNT_W'(QTR_CYCLES - 1);

    localparam logic [3:0] DEV_CODE = 4'b1010;  // 24c16 device type

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // host operation
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_t;

    // bit engine commands
    typedef enum logic [2:0] {
        CMD_START = 3'd0,
        CMD_STOP  = 3'd1,
        CMD_WRITE = 3'd2,  // byte out, sample ack
        CMD_READ  = 3'd3   // byte in, then ack or nack
    } bit_cmd_t;

endpackage

//--- logic/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  bit_cmd_t          cmd,
    input  logic [DATA_W-1:0] tx_byte,
    input  logic              tx_nack,
    output logic              busy,
    output logic              done,
    output logic              ack_seen,
    output logic [DATA_W-1:0] rx_byte,
    output logic              scl,
    output logic              sda_low,
    input  logic              sda_in
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_STOP,
        PH_WRITE,
        PH_READ
    } phase_t;

    phase_t              phase;
    logic [QCNT_W-1:0]   qcnt;     // clk count inside a quarter
    logic [1:0]          qtr;      // quarter inside a bit
    logic [3:0]          bit_cnt;  // 0..7 data, 8 is the ack slot
    logic [DATA_W-1:0]   shreg;
    logic                nack_q;
    logic                qtr_first;
    logic                qtr_last;
    logic                last_bit;

    assign qtr_first = (qcnt == '0);
    assign qtr_last  = (qcnt == QCNT_LAST);
    assign last_bit  = (bit_cnt == 4'd8);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase    <= PH_IDLE;
            qcnt     <= '0;
            qtr      <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            ack_seen <= 1'b0;
            scl      <= 1'b1;  // idle bus
            sda_low  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (phase == PH_IDLE)
            begin
                if (cmd_valid)
                begin
                    busy    <= 1'b1;
                    qcnt    <= '0;
                    qtr     <= '0;
                    bit_cnt <= '0;
                    case (cmd)
                        CMD_START: phase <= PH_START;
                        CMD_STOP:  phase <= PH_STOP;
                        CMD_WRITE: phase <= PH_WRITE;
                        default:   phase <= PH_READ;
                    endcase
                end
            end
            else
            begin
                // line changes happen on the first clk of each quarter
                if (qtr_first)
                begin
                    case (qtr)
                        2'd0:
                        begin
                            scl <= 1'b0;
                            case (phase)
                                PH_START: sda_low <= 1'b0;  // release before rise
                                PH_STOP:  sda_low <= 1'b1;
                                PH_WRITE: sda_low <= ~last_bit & ~shreg[DATA_W-1];
                                default:  sda_low <= last_bit & ~nack_q;  // master ack
                            endcase
                        end
                        2'd1:
                        begin
                            scl <= 1'b1;
                        end
                        2'd2:
                        begin
                            // middle of scl high
                            if (phase == PH_START)
                                sda_low <= 1'b1;  // start condition
                            else if (phase == PH_STOP)
                                sda_low <= 1'b0;  // stop condition
                            else if (phase == PH_WRITE && last_bit)
                                ack_seen <= ~sda_in;
                        end
                        default:
                        begin
                            if (phase != PH_STOP)
                                scl <= 1'b0;
                        end
                    endcase
                end

                if (qtr_last)
                begin
                    qcnt <= '0;
                    qtr  <= qtr + 2'd1;
                    if (qtr == 2'd3)
                    begin
                        if (phase == PH_START || phase == PH_STOP || last_bit)
                        begin
                            phase <= PH_IDLE;
                            busy  <= 1'b0;
                            done  <= 1'b1;
                        end
                        else
                            bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                else
                    qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (phase == PH_IDLE && cmd_valid)
        begin
            shreg  <= tx_byte;
            nack_q <= tx_nack;
        end
        else if (phase == PH_WRITE && qtr_last && qtr == 2'd3)
            shreg <= {shreg[DATA_W-2:0], 1'b0};  // msb first

        if (phase == PH_READ && qtr_first && qtr == 2'd2 && !last_bit)
            rx_byte <= {rx_byte[DATA_W-2:0], sda_in};
    end

endmodule

//--- logic/eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req,
    input  op_t               op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic              ack,
    output logic              err,
    output logic [DATA_W-1:0] rdata,
    output logic              cmd_valid,
    output bit_cmd_t          cmd,
    output logic [DATA_W-1:0] tx_byte,
    output logic              tx_nack,
    input  logic              busy,
    input  logic              done,
    input  logic              ack_seen,
    input  logic [DATA_W-1:0] rx_byte
);

    // one-hot main state
    typedef enum logic [9:0] {
        S_IDLE   = 10'b00_0000_0001,
        S_START  = 10'b00_0000_0010,
        S_CTRL_W = 10'b00_0000_0100,
        S_ADDR_W = 10'b00_0000_1000,
        S_DATA_W = 10'b00_0001_0000,
        S_RSTART = 10'b00_0010_0000,
        S_CTRL_R = 10'b00_0100_0000,
        S_DATA_R = 10'b00_1000_0000,
        S_STOP   = 10'b01_0000_0000,
        S_HACK   = 10'b10_0000_0000
    } state_t;

    state_t              state;
    logic                issued;  // waiting for done
    logic                issue;
    logic                in_cmd_state;
    op_t                 op_q;
    logic [ADDR_W-1:0]   addr_q;
    logic [DATA_W-1:0]   wdata_q;
    bit_cmd_t            next_cmd;
    logic [DATA_W-1:0]   next_byte;

    assign in_cmd_state = !(state inside {S_IDLE, S_HACK});
    assign issue        = in_cmd_state && !issued && !busy;

    // command and byte for the current state
    always_comb
    begin
        next_cmd  = CMD_START;
        next_byte = '0;
        case (state)
            S_CTRL_W:
            begin
                next_cmd  = CMD_WRITE;
                next_byte = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], 1'b0};  // block select
            end
            S_ADDR_W:
            begin
                next_cmd  = CMD_WRITE;
                next_byte = addr_q[DATA_W-1:0];
            end
            S_DATA_W:
            begin
                next_cmd  = CMD_WRITE;
                next_byte = wdata_q;
            end
            S_CTRL_R:
            begin
                next_cmd  = CMD_WRITE;
                next_byte = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], 1'b1};  // read bit
            end
            S_DATA_R: next_cmd = CMD_READ;
            S_STOP:   next_cmd = CMD_STOP;
            default:  next_cmd = CMD_START;  // start and repeated start
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            issued    <= 1'b0;
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            err       <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            if (issue)
            begin
                cmd_valid <= 1'b1;
                issued    <= 1'b1;
            end

            case (state)
                S_IDLE:
                begin
                    if (req)
                    begin
                        err   <= 1'b0;
                        state <= S_START;
                    end
                end
                S_HACK:
                begin
                    if (!req)  // four-phase release
                    begin
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default:
                begin
                    if (issued && done)
                    begin
                        issued <= 1'b0;
                        // missing slave ack on any written byte
                        if (state inside {S_CTRL_W, S_ADDR_W, S_DATA_W, S_CTRL_R} && !ack_seen)
                            err <= 1'b1;
                        case (state)
                            S_START:  state <= S_CTRL_W;
                            S_CTRL_W: state <= ack_seen ? S_ADDR_W : S_STOP;
                            S_ADDR_W:
                            begin
                                if (!ack_seen)
                                    state <= S_STOP;
                                else if (op_q == OP_WRITE)
                                    state <= S_DATA_W;
                                else
                                    state <= S_RSTART;
                            end
                            S_DATA_W: state <= S_STOP;
                            S_RSTART: state <= S_CTRL_R;
                            S_CTRL_R: state <= ack_seen ? S_DATA_R : S_STOP;
                            S_DATA_R: state <= S_STOP;
                            default:
                            begin
                                ack   <= 1'b1;  // stop sent, finish handshake
                                state <= S_HACK;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && req)
        begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (issue)
        begin
            cmd     <= next_cmd;
            tx_byte <= next_byte;
            tx_nack <= (state == S_DATA_R);  // single byte read ends with nack
        end
        if (state == S_DATA_R && issued && done)
            rdata <= rx_byte;
    end

endmodule

//--- logic/eeprom_top.sv
`timescale 1ns/1ps

module eeprom_top import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req,
    input  op_t               op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic              ack,
    output logic              err,
    output logic [DATA_W-1:0] rdata,
    output logic              scl,
    output logic              sda_low,
    input  logic              sda_in
);

    // sequencer to bit engine
    logic              cmd_valid;
    bit_cmd_t          cmd;
    logic [DATA_W-1:0] tx_byte;
    logic              tx_nack;
    logic              busy;
    logic              done;
    logic              ack_seen;
    logic [DATA_W-1:0] rx_byte;

    eeprom_ctrl ctrl0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .err       (err),
        .rdata     (rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_nack   (tx_nack),
        .busy      (busy),
        .done      (done),
        .ack_seen  (ack_seen),
        .rx_byte   (rx_byte)
    );

    i2c_bit_engine eng0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_nack   (tx_nack),
        .busy      (busy),
        .done      (done),
        .ack_seen  (ack_seen),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

endmodule

//--- sim/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,       // resolved line
    output logic sda_pull   // slave pulls sda low
);

    localparam logic [10:0] WP_BASE = 11'h700;  // upper block is read only

    typedef enum logic [1:0] {
        M_IDLE,
        M_RX,
        M_TX
    } mode_t;

    logic [7:0]  mem [0:2047];
    mode_t       mode;
    logic        scl_d;
    logic        sda_d;
    logic [3:0]  bit_cnt;
    logic [7:0]  shreg;
    logic [7:0]  txsh;
    logic [1:0]  byte_idx;   // 0 control, 1 word address, 2 data
    logic [2:0]  block;
    logic [7:0]  word;
    logic        rd_mode;
    logic        acked;
    logic        pend_wr;
    logic [7:0]  pend_data;
    logic        scl_rise;
    logic        scl_fall;
    logic        start_cond;
    logic        stop_cond;

    assign scl_rise   = scl & ~scl_d;
    assign scl_fall   = ~scl & scl_d;
    assign start_cond = scl & scl_d & sda_d & ~sda;
    assign stop_cond  = scl & scl_d & ~sda_d & sda;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                mem[i] <= 8'hFF;
            mode     <= M_IDLE;
            scl_d    <= 1'b1;
            sda_d    <= 1'b1;
            sda_pull <= 1'b0;
            bit_cnt  <= '0;
            byte_idx <= '0;
            block    <= '0;
            word     <= '0;
            rd_mode  <= 1'b0;
            acked    <= 1'b0;
            pend_wr  <= 1'b0;
        end
        else
        begin
            scl_d <= scl;
            sda_d <= sda;
            if (start_cond)
            begin
                mode     <= M_RX;
                bit_cnt  <= '0;
                byte_idx <= '0;
                sda_pull <= 1'b0;
                pend_wr  <= 1'b0;
            end
            else if (stop_cond)
            begin
                if (pend_wr)
                    mem[{block, word}] <= pend_data;  // write commits on stop
                pend_wr  <= 1'b0;
                mode     <= M_IDLE;
                sda_pull <= 1'b0;
            end
            else if (scl_rise && mode == M_RX && bit_cnt < 4'd8)
            begin
                shreg   <= {shreg[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (scl_fall && mode == M_RX && bit_cnt == 4'd8)
            begin
                // byte complete, decide the ack
                bit_cnt  <= 4'd9;
                byte_idx <= (byte_idx == 2'd3) ? 2'd3 : byte_idx + 2'd1;
                acked    <= 1'b0;
                sda_pull <= 1'b0;
                case (byte_idx)
                    2'd0:
                    begin
                        if (shreg[7:4] == 4'b1010)
                        begin
                            acked    <= 1'b1;
                            sda_pull <= 1'b1;
                            block    <= shreg[3:1];
                            rd_mode  <= shreg[0];
                        end
                    end
                    2'd1:
                    begin
                        word     <= shreg;
                        acked    <= 1'b1;
                        sda_pull <= 1'b1;
                    end
                    default:
                    begin
                        if ({block, word} < WP_BASE)
                        begin
                            acked     <= 1'b1;
                            sda_pull  <= 1'b1;
                            pend_wr   <= 1'b1;
                            pend_data <= shreg;
                        end
                    end
                endcase
            end
            else if (scl_fall && mode == M_RX && bit_cnt == 4'd9)
            begin
                if (!acked)
                begin
                    mode     <= M_IDLE;  // nack, master will stop
                    sda_pull <= 1'b0;
                end
                else if (rd_mode)
                begin
                    mode     <= M_TX;
                    txsh     <= mem[{block, word}];
                    sda_pull <= ~mem[{block, word}][7];
                    bit_cnt  <= '0;
                end
                else
                begin
                    sda_pull <= 1'b0;
                    bit_cnt  <= '0;
                end
            end
            else if (scl_fall && mode == M_TX)
            begin
                if (bit_cnt < 4'd7)
                begin
                    sda_pull <= ~txsh[6];
                    txsh     <= {txsh[6:0], 1'b0};
                    bit_cnt  <= bit_cnt + 4'd1;
                end
                else if (bit_cnt == 4'd7)
                begin
                    sda_pull <= 1'b0;  // master ack slot
                    bit_cnt  <= 4'd8;
                end
                else
                    mode <= M_IDLE;
            end
        end
    end

endmodule

//--- sim/eeprom_bus_checker.sv
`timescale 1ns/1ps

module eeprom_bus_checker import eeprom_pkg::*; (
    input logic              CLK,
    input logic              RESET,
    input logic              req,
    input logic              ack,
    input op_t               op,
    input logic [ADDR_W-1:0] addr,
    input logic [DATA_W-1:0] wdata,
    input logic              scl,
    input logic              sda_low,
    input logic [9:0]        ctrl_state
);

    logic start_stop;

    // start, repeated start and stop states of the sequencer
    assign start_stop = ctrl_state[1] | ctrl_state[5] | ctrl_state[8];

    ack_rise_with_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(ack) |-> req) else $error("ack rose without req");

    ack_fall_after_req: assert property (@(posedge CLK) disable iff (RESET)
        $fell(ack) |-> !$past(req)) else $error("ack fell while req was high");

    req_fields_stable: assert property (@(posedge CLK) disable iff (RESET)
        (req && !ack && $past(req && !ack)) |-> ($stable(op) && $stable(addr) && $stable(wdata)))
        else $error("request fields changed during a pending request");

    sda_change_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_low) |-> (!scl || start_stop)) else $error("sda moved while scl high");

endmodule

bind eeprom_top eeprom_bus_checker chk0 (
    .CLK        (CLK),
    .RESET      (RESET),
    .req        (req),
    .ack        (ack),
    .op         (op),
    .addr       (addr),
    .wdata      (wdata),
    .scl        (scl),
    .sda_low    (sda_low),
    .ctrl_state (ctrl0.state)
);

//--- sim/eeprom_tb.sv
`timescale 1ns/1ps

module eeprom_tb import eeprom_pkg::*; ();

    localparam int TIMEOUT = 2000;  // cycles per wait

    logic              CLK;
    logic              RESET;
    logic              req;
    op_t               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] rdata;
    logic              scl;
    logic              sda_low;
    logic              sda_in;
    logic              model_pull;

    assign sda_in = ~(sda_low | model_pull);  // wired-and with pull-up

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    eeprom_top dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .ack     (ack),
        .err     (err),
        .rdata   (rdata),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

    eeprom_model model0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .sda      (sda_in),
        .sda_pull (model_pull)
    );

    task automatic wait_for_ack(input logic level);
        int cnt;
        cnt = 0;
        while (ack !== level && cnt <= TIMEOUT)
        begin
            @(posedge CLK);
            cnt++;
        end
        if (ack !== level)
        begin
            $display("SIMULATION FAILED");
            $display("timed out waiting for ack to become %0b", level);
            $fatal(1, "ack wait timeout");
        end
    endtask

    task automatic check_rdata(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                               input logic [ADDR_W-1:0] a);
        if (got !== exp)
        begin
            $display("ERROR at %0t: rdata at addr %h is %h, expected %h", $time, a, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "rdata mismatch");
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input logic [ADDR_W-1:0] a);
        if (got !== exp)
        begin
            $display("ERROR at %0t: err at addr %h is %b, expected %b", $time, a, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "err mismatch");
        end
    endtask

    task automatic do_request(input op_t o, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] exp_r,
                              input logic exp_e);
        @(posedge CLK);
        req   <= 1'b1;
        op    <= o;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wait_for_ack(1'b1);
        check_err(err, exp_e, a);
        if (o == OP_READ)
            check_rdata(rdata, exp_r, a);
        req <= 1'b0;
        wait_for_ack(1'b0);
    endtask

    initial
    begin
        int          fd;
        int          n;
        int          n_req;
        int          gap;
        int          opv;
        logic [31:0] addrv;
        logic [31:0] wv;
        logic [31:0] exp_r;
        int          exp_e;
        string       line;

        n_req = 0;
        gap   = $urandom(35);
        RESET = 1'b1;
        req   = 1'b0;
        op    = OP_WRITE;
        addr  = '0;
        wdata = '0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;

        fd = $fopen("sim/eeprom_input.txt", "r");
        if (fd == 0)
        begin
            $display("SIMULATION FAILED");
            $display("could not open the stimulus file sim/eeprom_input.txt");
            $fatal(1, "missing stimulus file");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != 8'h23)
                begin
                    n = $sscanf(line, "%d %h %h %h %d", opv, addrv, wv, exp_r, exp_e);
                    if (n == 5)
                    begin
                        gap = $urandom_range(0, 7);  // idle gap may be zero
                        repeat (gap) @(posedge CLK);
                        do_request(op_t'(opv[0]), addrv[ADDR_W-1:0], wv[DATA_W-1:0],
                                   exp_r[DATA_W-1:0], exp_e[0]);
                        n_req++;
                    end
                end
            end
            $fclose(fd);

            if (n_req > 0)
            begin
                $display("SIMULATION PASSED");
                $finish;
            end
            else
            begin
                $display("SIMULATION FAILED");
                $display("the stimulus file held no requests");
                $fatal(1, "empty stimulus");
            end
        end
    end

endmodule

//--- sim/eeprom_input.txt
# op (0 write, 1 read)  addr (hex)  wdata (hex)  expected rdata (hex)  expected err
# rdata is checked for reads only
0 123 a5 00 0
1 123 00 a5 0
0 010 11 00 0
0 110 22 00 0
0 210 33 00 0
0 610 66 00 0
1 010 00 11 0
1 110 00 22 0
1 210 00 33 0
1 610 00 66 0
1 555 00 ff 0
1 000 00 ff 0
0 700 5a 00 1
1 700 00 ff 0
0 7ff 00 00 1
1 7ff 00 ff 0
0 6ff 77 00 0
1 6ff 00 77 0
0 3ab c3 00 0
1 3ab 00 c3 0
0 3ac 3c 00 0
1 3ac 00 3c 0
1 123 00 a5 0
0 123 96 00 0
1 123 00 96 0
0 4f0 01 00 0
0 4f1 80 00 0
1 4f0 00 01 0
1 4f1 00 80 0
1 310 00 ff 0
0 000 00 00 0
1 000 00 00 0
0 7fe 12 00 1
1 7fe 00 ff 0
0 5ff ee 00 0
1 5ff 00 ee 0
1 010 00 11 0
1 610 00 66 0

//--- compile.f
logic/eeprom_pkg.sv
logic/i2c_bit_engine.sv
logic/eeprom_ctrl.sv
logic/eeprom_top.sv
sim/eeprom_model.sv
sim/eeprom_bus_checker.sv
sim/eeprom_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench, exit status reflects the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module eeprom_tb -f compile.f -o eeprom_sim \
    && ./obj_dir/eeprom_sim \
    || { echo "build or simulation failed"; exit 1; }
